//--- filelist.f
cam_bist_pkg.sv
cam_port_if.sv
cam_bist_inhandler.sv
cam_array.sv
cam_match_checker.sv
cam_bist_ctrl.sv
cam_bist_top.sv
tb_cam_bist.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cam_bist
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_cam_bist.sv
`timescale 1ns/1ps

module tb_cam_bist import cam_bist_pkg::*; ();

   localparam int MASK_PASSES  = 4;
   localparam int ACK_TIMEOUT  = 20;
   localparam int DONE_TIMEOUT = 100;

   logic       bist_clk;
   logic       rst_b;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   wb_addr_t   wb_adr;
   wb_data_t   wb_dat_w;
   wb_data_t   wb_dat_r;
   logic       wb_ack;

   // Reference CAM contents, valid bits, background and mask position
   logic [31:0] rng_state;
   cam_data_t   model_mem [CAM_ENTRIES];
   cam_match_t  model_valid;
   cam_data_t   model_pattern;
   int          mask_pos;
   int          value_errors;
   int          timeout_errors;

   cam_bist_top #(
      .MASK_PASSES(MASK_PASSES)
   ) cam_bist_top_inst (
      .bist_clk(bist_clk), .rst_b(rst_b),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   initial begin
      bist_clk = 1'b0;
      forever #50 bist_clk = ~bist_clk;
   end

   // --------------------
   // Model
   // --------------------
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Valid entries that hold the key
   function automatic cam_match_t model_search(input cam_data_t key);
      cam_match_t v;
      v = '0;
      for (int i = 0; i < CAM_ENTRIES; i++) begin
         v[i] = model_valid[i] && (model_mem[i] == key);
      end
      return v;
   endfunction

   // One-hot at the key's low bits when its upper bits fit the background
   function automatic cam_match_t expected_hit(input cam_data_t key, input logic inv);
      cam_data_t  bg;
      cam_match_t v;
      bg = model_pattern ^ {CAM_DATA_W{inv}};
      v  = '0;
      if (key[CAM_DATA_W-1:CAM_IDX_W] == bg[CAM_DATA_W-1:CAM_IDX_W]) begin
         v[key[CAM_IDX_W-1:0]] = 1'b1;
      end
      return v;
   endfunction

   // Replays one self-test run and predicts fail count and first failing index
   task automatic model_bist(input logic cmp_only, input logic inv,
                             output logic [7:0] cnt, output cam_idx_t first);
      logic [CAM_DATA_W-CAM_IDX_W-1:0] bg_hi;
      cam_data_t base;
      cam_data_t key;
      // Background XOR invert above the index bits
      bg_hi = model_pattern[CAM_DATA_W-1:CAM_IDX_W] ^ {(CAM_DATA_W-CAM_IDX_W){inv}};
      if (!cmp_only) begin
         mask_pos = 0;
         for (int i = 0; i < CAM_ENTRIES; i++) begin
            model_mem[i]   = {bg_hi, 4'(i)};
            model_valid[i] = 1'b1;
         end
      end
      cnt   = '0;
      first = '0;
      for (int i = 0; i < CAM_ENTRIES; i++) begin
         base = {bg_hi, 4'(i)};
         // Pass 0 is unmasked and the rest flip one rotating bit
         for (int p = 0; p <= MASK_PASSES; p++) begin
            key = base;
            if (p != 0) begin
               key      = base ^ (cam_data_t'(1) << mask_pos);
               mask_pos = (mask_pos + 1) % CAM_DATA_W;
            end
            if (model_search(key) != expected_hit(key, inv)) begin
               if (cnt == 8'd0) begin
                  first = key[CAM_IDX_W-1:0];
               end
               if (cnt != 8'hff) begin
                  cnt = cnt + 8'd1;
               end
            end
         end
      end
   endtask

   // --------------------
   // Compare tasks
   // --------------------
   task automatic check_reg(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_match(input string name, input cam_match_t got, input cam_match_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_idx(input string name, input cam_idx_t got, input cam_idx_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // --------------------
   // Register port
   // --------------------
   // One classic cycle with ack sampled on the falling edge
   task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                            output wb_data_t rdat);
      int waited;
      // Idle gap lets the last search reach the MATCH register
      repeat (2) @(posedge bist_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      waited = 0;
      @(negedge bist_clk);
      while (!wb_ack && waited < ACK_TIMEOUT) begin
         @(negedge bist_clk);
         waited++;
      end
      if (!wb_ack) begin
         timeout_errors++;
         $display("Timeout: no ack from register %0d", adr);
      end
      rdat = wb_dat_r;
      @(posedge bist_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic write_reg(input wb_addr_t adr, input wb_data_t wdat);
      wb_data_t unused;
      bus_cycle(1'b1, adr, wdat, unused);
   endtask

   task automatic read_reg(input wb_addr_t adr, output wb_data_t rdat);
      bus_cycle(1'b0, adr, '0, rdat);
   endtask

   task automatic func_load(input cam_idx_t idx, input cam_data_t data);
      write_reg(REG_FUNC_WR, {12'd0, idx, data});
      model_mem[idx]   = data;
      model_valid[idx] = 1'b1;
   endtask

   task automatic func_search(input cam_data_t key);
      wb_data_t rd;
      write_reg(REG_FUNC_KEY, {16'd0, key});
      read_reg(REG_MATCH, rd);
      check_match("match", rd[CAM_ENTRIES-1:0], model_search(key));
   endtask

   // Start, optionally poke the CAM while busy, poll for done and check status
   task automatic run_bist(input logic cmp_only, input logic inv, input logic meddle);
      wb_data_t   rd;
      wb_data_t   wdat;
      int         polls;
      logic [7:0] exp_cnt;
      cam_idx_t   exp_idx;
      write_reg(REG_CTRL, {29'd0, inv, cmp_only, 1'b1});
      if (meddle) begin
         read_reg(REG_STATUS, rd);
         check_reg("status busy", {31'd0, rd[0]}, 32'd1);
         // Both must be dropped by the controller
         wdat = next_random();
         write_reg(REG_FUNC_WR, wdat & 32'h000f_ffff);
         wdat = next_random();
         write_reg(REG_FUNC_KEY, wdat & 32'h0000_ffff);
      end
      rd    = '0;
      polls = 0;
      while (!rd[1] && polls < DONE_TIMEOUT) begin
         read_reg(REG_STATUS, rd);
         polls++;
      end
      if (!rd[1]) begin
         timeout_errors++;
         $display("Timeout: self-test never reported done");
      end
      model_bist(cmp_only, inv, exp_cnt, exp_idx);
      check_reg("status", rd, {16'd0, exp_cnt, 5'd0, exp_cnt != 8'd0, 1'b1, 1'b0});
      read_reg(REG_FAIL_IDX, rd);
      check_idx("fail_idx", rd[CAM_IDX_W-1:0], exp_idx);
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      wb_data_t  rd;
      wb_data_t  wdat;
      cam_data_t key;
      rng_state      = 32'h74d;
      value_errors   = 0;
      timeout_errors = 0;
      mask_pos       = 0;
      model_valid    = '0;
      model_pattern  = '0;
      for (int i = 0; i < CAM_ENTRIES; i++) begin
         model_mem[i] = '0;
      end
      rst_b    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      repeat (8) @(posedge bist_clk);
      rst_b <= 1'b1;

      // Reset values and pattern read-back
      read_reg(REG_STATUS, rd);
      check_reg("status", rd, 32'd0);
      read_reg(REG_MATCH, rd);
      check_reg("match", rd, 32'd0);
      for (int n = 0; n < 4; n++) begin
         wdat = next_random();
         write_reg(REG_PATTERN, wdat);
         model_pattern = wdat[CAM_DATA_W-1:0];
         read_reg(REG_PATTERN, rd);
         check_reg("pattern", rd, {16'd0, model_pattern});
      end

      // Functional loads with one word stored twice for a multi-hit
      for (int n = 0; n < 12; n++) begin
         wdat = next_random();
         func_load(wdat[19:16], wdat[15:0]);
      end
      wdat = next_random();
      func_load(4'd2, wdat[15:0]);
      func_load(4'd9, wdat[15:0]);
      for (int n = 0; n < 16; n++) begin
         wdat = next_random();
         key  = wdat[31] ? model_mem[wdat[19:16]] : wdat[15:0];
         func_search(key);
      end

      // Full runs with a plain then an inverted background
      for (int n = 0; n < 2; n++) begin
         wdat = next_random();
         write_reg(REG_PATTERN, wdat);
         model_pattern = wdat[CAM_DATA_W-1:0];
         run_bist(1'b0, n == 1, 1'b0);
         for (int i = 0; i < CAM_ENTRIES; i++) begin
            func_search(model_mem[i]);
         end
      end

      // Compare-only over partly overwritten contents
      for (int n = 0; n < 2; n++) begin
         for (int k = 0; k < 6; k++) begin
            wdat = next_random();
            func_load(wdat[19:16], wdat[15:0]);
         end
         wdat = next_random();
         run_bist(1'b1, wdat[0], 1'b0);
      end

      // CAM accesses while busy leave the contents alone
      wdat = next_random();
      run_bist(1'b1, wdat[0], 1'b1);
      for (int i = 0; i < CAM_ENTRIES; i++) begin
         func_search(model_mem[i]);
      end

      $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- cam_bist_top.sv
`timescale 1ns/1ps

module cam_bist_top import cam_bist_pkg::*; #(
   parameter int MASK_PASSES = 4
) (
   input  logic     bist_clk,
   input  logic     rst_b,
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_addr_t wb_adr,
   input  wb_data_t wb_dat_w,
   output wb_data_t wb_dat_r,
   output logic     wb_ack
);

   // Controller to handler
   logic       bist_mode;
   logic       invert;
   logic       mask_en;
   logic       rotate;
   logic       mask_clear;
   logic       bist_wr_en;
   cam_idx_t   bist_wr_idx;
   cam_data_t  bist_wr_data;
   logic       func_wr_en;
   cam_idx_t   func_wr_idx;
   cam_data_t  func_wr_data;
   logic       func_cm_en;
   cam_data_t  func_key;

   // Controller and checker
   logic       check_en;
   logic       checker_clear;
   cam_data_t  exp_base;
   logic       exp_invert;
   logic       fail;
   logic [7:0] fail_count;
   cam_idx_t   fail_idx;

   // --------------------
   // CAM port bundle
   // --------------------
   cam_port_if cam (.bist_clk(bist_clk));

   cam_bist_ctrl #(
      .MASK_PASSES(MASK_PASSES)
   ) u_ctrl (
      .bist_clk(bist_clk), .rst_b(rst_b),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .bist_mode(bist_mode), .invert(invert), .mask_en(mask_en),
      .rotate(rotate), .mask_clear(mask_clear),
      .bist_wr_en(bist_wr_en), .bist_wr_idx(bist_wr_idx), .bist_wr_data(bist_wr_data),
      .func_wr_en(func_wr_en), .func_wr_idx(func_wr_idx), .func_wr_data(func_wr_data),
      .func_cm_en(func_cm_en), .func_key(func_key),
      .check_en(check_en), .checker_clear(checker_clear),
      .exp_base(exp_base), .exp_invert(exp_invert),
      .fail(fail), .fail_count(fail_count), .fail_idx(fail_idx),
      .last_match(cam.match)
   );

   cam_bist_inhandler u_inhandler (
      .bist_clk(bist_clk), .rst_b(rst_b),
      .bist_mode(bist_mode), .invert(invert), .mask_en(mask_en),
      .rotate(rotate), .mask_clear(mask_clear),
      .bist_wr_en(bist_wr_en), .bist_wr_idx(bist_wr_idx), .bist_wr_data(bist_wr_data),
      .func_wr_en(func_wr_en), .func_wr_idx(func_wr_idx), .func_wr_data(func_wr_data),
      .func_cm_en(func_cm_en), .func_key(func_key),
      .cam(cam.handler)
   );

   cam_array u_array (.bist_clk(bist_clk), .rst_b(rst_b), .cam(cam.array));

   // Checks only while the self-test owns the array
   cam_match_checker u_checker (
      .bist_clk(bist_clk), .rst_b(rst_b),
      .check_en(check_en), .clear(checker_clear),
      .exp_base(exp_base), .exp_invert(exp_invert),
      .cam(cam.monitor),
      .fail(fail), .fail_count(fail_count), .fail_idx(fail_idx)
   );

endmodule

//--- cam_bist_ctrl.sv
`timescale 1ns/1ps

module cam_bist_ctrl import cam_bist_pkg::*; #(
   parameter int MASK_PASSES = 4
) (
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  wb_addr_t   wb_adr,
   input  wb_data_t   wb_dat_w,
   output wb_data_t   wb_dat_r,
   output logic       wb_ack,
   output logic       bist_mode,
   output logic       invert,
   output logic       mask_en,
   output logic       rotate,
   output logic       mask_clear,
   output logic       bist_wr_en,
   output cam_idx_t   bist_wr_idx,
   output cam_data_t  bist_wr_data,
   output logic       func_wr_en,
   output cam_idx_t   func_wr_idx,
   output cam_data_t  func_wr_data,
   output logic       func_cm_en,
   output cam_data_t  func_key,
   output logic       check_en,
   output logic       checker_clear,
   output cam_data_t  exp_base,
   output logic       exp_invert,
   input  logic       fail,
   input  logic [7:0] fail_count,
   input  cam_idx_t   fail_idx,
   input  cam_match_t last_match
);

   bist_state_t state;
   cam_data_t   pattern;
   logic        cfg_cmp_only;
   logic        cfg_invert;
   logic        busy;
   logic        done;
   cam_idx_t    idx;
   logic [3:0]  pass_cnt;
   logic        key_go;
   logic        srch_d;
   cam_match_t  match_q;
   logic        wb_req;
   logic        wb_wr;
   logic        start;

   // --------------------
   // Wishbone slave
   // --------------------
   assign wb_req = wb_cyc && wb_stb;
   // Writes land in the ack cycle
   assign wb_wr  = wb_req && wb_we && wb_ack;
   assign start  = wb_wr && (wb_adr == REG_CTRL) && wb_dat_w[0] && !busy;

   // Ack one cycle after the request, drops with stb
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_req && !wb_ack;
      end
   end

   // Read data registered alongside ack
   always_ff @(posedge bist_clk) begin
      if (wb_req && !wb_ack) begin
         case (wb_adr)
            REG_CTRL:     wb_dat_r <= {29'd0, cfg_invert, cfg_cmp_only, 1'b0};
            REG_PATTERN:  wb_dat_r <= {16'd0, pattern};
            REG_STATUS:   wb_dat_r <= {16'd0, fail_count, 5'd0, fail, done, busy};
            REG_FAIL_IDX: wb_dat_r <= {28'd0, fail_idx};
            REG_MATCH:    wb_dat_r <= {16'd0, match_q};
            default:      wb_dat_r <= '0;
         endcase
      end
   end

   // Configuration is frozen while the self-test runs
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         pattern      <= '0;
         cfg_cmp_only <= 1'b0;
         cfg_invert   <= 1'b0;
      end else if (wb_wr && !busy) begin
         if (wb_adr == REG_CTRL) begin
            cfg_cmp_only <= wb_dat_w[1];
            cfg_invert   <= wb_dat_w[2];
         end
         if (wb_adr == REG_PATTERN) begin
            pattern <= wb_dat_w[CAM_DATA_W-1:0];
         end
      end
   end

   // --------------------
   // Functional path
   // --------------------
   // Strobes, dropped while busy
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         func_wr_en <= 1'b0;
         key_go     <= 1'b0;
      end else begin
         func_wr_en <= wb_wr && (wb_adr == REG_FUNC_WR) && !busy;
         key_go     <= wb_wr && (wb_adr == REG_FUNC_KEY) && !busy;
      end
   end

   // Payload for the strobes above
   always_ff @(posedge bist_clk) begin
      if (wb_wr && (wb_adr == REG_FUNC_WR)) begin
         func_wr_idx  <= wb_dat_w[19:16];
         func_wr_data <= wb_dat_w[15:0];
      end
      if (wb_wr && (wb_adr == REG_FUNC_KEY)) begin
         func_key <= wb_dat_w[15:0];
      end
   end

   // Last match vector, taken one cycle after any search
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         srch_d  <= 1'b0;
         match_q <= '0;
      end else begin
         srch_d <= func_cm_en;
         if (srch_d) begin
            match_q <= last_match;
         end
      end
   end

   // --------------------
   // Self-test FSM
   // --------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state    <= IDLE;
         busy     <= 1'b0;
         done     <= 1'b0;
         idx      <= '0;
         pass_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  busy  <= 1'b1;
                  done  <= 1'b0;
                  idx   <= '0;
                  // Compare-only leaves the loaded contents alone
                  state <= wb_dat_w[1] ? SEARCH : WRITE;
               end
            end
            WRITE: begin
               idx <= idx + 1'b1;
               if (idx == cam_idx_t'(CAM_ENTRIES-1)) begin
                  state <= SEARCH;
               end
            end
            SEARCH:      state <= SEARCH_WAIT;
            SEARCH_WAIT: begin
               pass_cnt <= '0;
               state    <= MASK_SEARCH;
            end
            MASK_SEARCH: state <= MASK_WAIT;
            MASK_WAIT: begin
               if (pass_cnt == 4'(MASK_PASSES-1)) begin
                  if (idx == cam_idx_t'(CAM_ENTRIES-1)) begin
                     state <= DONE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= SEARCH;
                  end
               end else begin
                  pass_cnt <= pass_cnt + 1'b1;
                  state    <= MASK_SEARCH;
               end
            end
            // Last result has reached the fail flag by now
            DONE: begin
               busy  <= 1'b0;
               done  <= 1'b1;
               state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Sequencer outputs decoded from state
   assign bist_mode     = busy;
   assign invert        = cfg_invert;
   assign bist_wr_en    = (state == WRITE);
   assign bist_wr_idx   = idx;
   assign bist_wr_data  = {pattern[CAM_DATA_W-1:CAM_IDX_W], idx};
   assign mask_en       = (state == MASK_SEARCH);
   assign rotate        = (state == MASK_SEARCH); // advance after each masked key
   assign func_cm_en    = key_go || (state == SEARCH) || (state == MASK_SEARCH);

   // Full run restarts the mask, compare-only keeps its position
   assign mask_clear    = start && !wb_dat_w[1];
   assign checker_clear = start;
   assign check_en      = busy;
   assign exp_base      = pattern;
   assign exp_invert    = cfg_invert;

endmodule

//--- cam_match_checker.sv
`timescale 1ns/1ps

module cam_match_checker import cam_bist_pkg::*; (
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       check_en,
   input  logic       clear,
   input  cam_data_t  exp_base,
   input  logic       exp_invert,
   cam_port_if.monitor cam,
   output logic       fail,
   output logic [7:0] fail_count,
   output cam_idx_t   fail_idx
);

   cam_data_t  key_q;
   cam_data_t  bg;
   cam_match_t exp_match;
   logic       mismatch;

   // Key of the search whose result shows up next cycle
   always_ff @(posedge bist_clk) begin
      key_q <= cam.cm_data;
   end

   // --------------------
   // Expected match
   // --------------------
   // Array holds background XOR invert with the index in the low bits
   assign bg = exp_base ^ {CAM_DATA_W{exp_invert}};

   always_comb begin
      exp_match = '0;
      // Upper bits select whether any entry should hit
      if (key_q[CAM_DATA_W-1:CAM_IDX_W] == bg[CAM_DATA_W-1:CAM_IDX_W]) begin
         exp_match[key_q[CAM_IDX_W-1:0]] = 1'b1;
      end
   end

   assign mismatch = cam.match_valid && check_en && (cam.match != exp_match);

   // --------------------
   // Fail status
   // --------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         fail       <= 1'b0;
         fail_count <= '0;
         fail_idx   <= '0;
      end else if (clear) begin
         fail       <= 1'b0;
         fail_count <= '0;
         fail_idx   <= '0;
      end else if (mismatch) begin
         fail <= 1'b1;
         // Count saturates at 255
         if (fail_count != 8'hff) begin
            fail_count <= fail_count + 8'd1;
         end
         // Only the first failing entry is kept
         if (!fail) begin
            fail_idx <= key_q[CAM_IDX_W-1:0];
         end
      end
   end

endmodule

//--- cam_array.sv
`timescale 1ns/1ps

module cam_array import cam_bist_pkg::*; (
   input  logic bist_clk,
   input  logic rst_b,
   cam_port_if.array cam
);

   cam_data_t  mem [CAM_ENTRIES];
   cam_match_t valid;
   cam_match_t hit;

   // --------------------
   // Storage
   // --------------------
   // Word contents, no reset
   always_ff @(posedge bist_clk) begin
      if (cam.wr_en) begin
         mem[cam.wr_idx] <= cam.wr_data;
      end
   end

   // Entry valid bits, empty after reset
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         valid <= '0;
      end else if (cam.wr_en) begin
         valid[cam.wr_idx] <= 1'b1;
      end
   end

   // --------------------
   // Search
   // --------------------
   // Parallel compare of every valid entry against the key
   always_comb begin
      for (int i = 0; i < CAM_ENTRIES; i++) begin
         hit[i] = valid[i] && (mem[i] == cam.cm_data);
      end
   end

   // Result registered on the strobe
   always_ff @(posedge bist_clk) begin
      if (cam.cm_en) begin
         cam.match <= hit;
      end
   end

   // One-cycle valid pulse behind each strobe
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         cam.match_valid <= 1'b0;
      end else begin
         cam.match_valid <= cam.cm_en;
      end
   end

endmodule

//--- cam_bist_inhandler.sv
`timescale 1ns/1ps

module cam_bist_inhandler import cam_bist_pkg::*; (
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       bist_mode,
   input  logic       invert,
   input  logic       mask_en,
   input  logic       rotate,
   input  logic       mask_clear,
   input  logic       bist_wr_en,
   input  cam_idx_t   bist_wr_idx,
   input  cam_data_t  bist_wr_data,
   input  logic       func_wr_en,
   input  cam_idx_t   func_wr_idx,
   input  cam_data_t  func_wr_data,
   input  logic       func_cm_en,
   input  cam_data_t  func_key,
   cam_port_if.handler cam
);

   cam_data_t mask;
   cam_data_t wr_data_inv;
   cam_data_t cmp_data;

   // --------------------
   // Rotating flip mask
   // --------------------
   // Circular one-hot that comes out of reset at bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= cam_data_t'(1);
      end else if (mask_clear) begin
         mask <= cam_data_t'(1);
      end else if (rotate) begin
         // Bit 15 wraps back into bit 0
         mask <= {mask[CAM_DATA_W-2:0], mask[CAM_DATA_W-1]};
      end
   end

   // --------------------
   // Data generation
   // --------------------
   // Background bits invert while the index in the low bits stays as is
   assign wr_data_inv = bist_wr_data ^ {{(CAM_DATA_W-CAM_IDX_W){invert}}, {CAM_IDX_W{1'b0}}};

   // Compare key flips the single mask bit when masking is on
   assign cmp_data = wr_data_inv ^ ({CAM_DATA_W{mask_en}} & mask);

   // --------------------
   // Mode select
   // --------------------
   assign cam.wr_en   = bist_mode ? bist_wr_en  : func_wr_en;
   assign cam.wr_idx  = bist_mode ? bist_wr_idx : func_wr_idx;
   assign cam.wr_data = bist_mode ? wr_data_inv : func_wr_data;

   // The controller raises the shared search strobe for both paths
   assign cam.cm_en   = func_cm_en;
   assign cam.cm_data = bist_mode ? cmp_data : func_key;

endmodule

//--- cam_port_if.sv
`timescale 1ns/1ps

interface cam_port_if import cam_bist_pkg::*; (
   input logic bist_clk
);

   // Write port into the array
   logic       wr_en;
   cam_idx_t   wr_idx;
   cam_data_t  wr_data;

   // Search strobe and key
   logic       cm_en;
   cam_data_t  cm_data;

   // Registered search result, one cycle after cm_en
   cam_match_t match;
   logic       match_valid;

   // Input handler side, drives writes and searches
   modport handler (
      input  bist_clk,
      output wr_en, wr_idx, wr_data, cm_en, cm_data
   );

   // Storage side
   modport array (
      input  bist_clk,
      input  wr_en, wr_idx, wr_data, cm_en, cm_data,
      output match, match_valid
   );

   // Result checker only watches
   modport monitor (
      input  bist_clk,
      input  cm_data, match, match_valid
   );

endinterface

//--- cam_bist_pkg.sv
package cam_bist_pkg;

   // --------------------
   // CAM geometry
   // --------------------
   localparam int CAM_DATA_W  = 16;
   localparam int CAM_ENTRIES = 16;
   localparam int CAM_IDX_W   = 4;

   // One CAM word, one entry index, one bit per entry
   typedef logic [CAM_DATA_W-1:0]  cam_data_t;
   typedef logic [CAM_IDX_W-1:0]   cam_idx_t;
   typedef logic [CAM_ENTRIES-1:0] cam_match_t;

   // --------------------
   // Register port
   // --------------------
   typedef logic [2:0]  wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // Word addresses of the register map
   localparam wb_addr_t REG_CTRL     = 3'd0;
   localparam wb_addr_t REG_PATTERN  = 3'd1;
   localparam wb_addr_t REG_STATUS   = 3'd2;
   localparam wb_addr_t REG_FAIL_IDX = 3'd3;
   localparam wb_addr_t REG_FUNC_WR  = 3'd4;
   localparam wb_addr_t REG_FUNC_KEY = 3'd5;
   localparam wb_addr_t REG_MATCH    = 3'd6;

   // Self-test sequencer states
   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      SEARCH,
      SEARCH_WAIT,
      MASK_SEARCH,
      MASK_WAIT,
      DONE
   } bist_state_t;

endpackage
